// File: rtl/dma_ctrl_pkg.sv
package dma_ctrl_pkg;

  ////////////////////
  // control bus words
  ////////////////////

  typedef logic [31:0] lite_addr_t;
  typedef logic [31:0] lite_data_t;

  // master side of the write channels
  typedef struct packed {
    logic       awvalid;
    lite_addr_t awaddr;
    logic       wvalid;
    lite_data_t wdata;
  } lite_wr_req_t;

  typedef struct packed {
    logic awready;
    logic wready;
  } lite_wr_rsp_t;

  // read address plus rready, which stays high
  typedef struct packed {
    logic       arvalid;
    lite_addr_t araddr;
    logic       rready;
  } lite_rd_req_t;

  typedef struct packed {
    logic       arready;
    logic       rvalid;
    lite_data_t rdata;
  } lite_rd_rsp_t;

  ////////////////////
  // register map
  ////////////////////

  localparam lite_addr_t H2C_BASE      = 32'h0000_0000; // host to card block
  localparam lite_addr_t C2H_BASE      = 32'h0000_1000; // card to host block
  localparam lite_addr_t CHAN_STRIDE   = 32'h0000_0100;
  localparam lite_addr_t CTRL_REG_OFS  = 32'h0000_0004; // channel control reg
  localparam lite_data_t RUN_BIT_VALUE = 32'h0000_0001;
  localparam int         MAX_CHANNELS  = 4;

  // one-hot boot states
  typedef enum logic [3:0] {
    BOOT_IDLE = 4'b0001,
    BOOT_ADDR = 4'b0010,
    BOOT_DATA = 4'b0100,
    BOOT_DONE = 4'b1000
  } boot_state_t;

  // entry i hits channel (i/2 + 1) mod n, even i on h2c, odd i on c2h
  function automatic lite_addr_t boot_entry_addr(input int unsigned idx,
                                                 input int unsigned num_ch);
    int unsigned chan;
    lite_addr_t  base;
    chan = ((idx >> 1) + 1) % num_ch;
    base = idx[0] ? C2H_BASE : H2C_BASE;
    return base + lite_addr_t'(chan) * CHAN_STRIDE + CTRL_REG_OFS;
  endfunction

endpackage

// File: rtl/boot_config_seq.sv
`timescale 1ns/1ps

module boot_config_seq #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic                       pcie_clk,
  input  logic                       pcie_aresetn,
  output dma_ctrl_pkg::lite_wr_req_t wr_req,
  input  dma_ctrl_pkg::lite_wr_rsp_t wr_rsp,
  output logic                       cfg_done
);

  localparam int NUM_ENTRIES = 2 * NUM_CHANNELS;          // one h2c + one c2h per channel
  localparam int CNT_W = $clog2(2 * dma_ctrl_pkg::MAX_CHANNELS + 1);

  // channel count must fit the register map
  if (NUM_CHANNELS < 1 || NUM_CHANNELS > dma_ctrl_pkg::MAX_CHANNELS) begin : g_num_chk
    $error("boot_config_seq: NUM_CHANNELS out of range");
  end

  dma_ctrl_pkg::boot_state_t state;
  logic [CNT_W-1:0]          entry_cnt;                   // index of current table entry
  dma_ctrl_pkg::lite_addr_t  entry_addr;
  logic                      aw_fire;
  logic                      w_fire;
  logic                      table_end;

  assign aw_fire   = wr_req.awvalid & wr_rsp.awready;
  assign w_fire    = wr_req.wvalid & wr_rsp.wready;
  assign table_end = (entry_cnt == CNT_W'(NUM_ENTRIES));

  // address of the pending entry, held until the data transfer bumps the counter
  always_comb begin
    entry_addr = dma_ctrl_pkg::boot_entry_addr(entry_cnt, NUM_CHANNELS);
  end

  ////////////////////
  // sequencer fsm
  ////////////////////

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      state     <= dma_ctrl_pkg::BOOT_IDLE;
      entry_cnt <= '0;
    end else begin
      unique case (state)
        dma_ctrl_pkg::BOOT_IDLE: begin               // one gap cycle per entry
          if (table_end) begin
            state <= dma_ctrl_pkg::BOOT_DONE;
          end else begin
            state <= dma_ctrl_pkg::BOOT_ADDR;
          end
        end
        dma_ctrl_pkg::BOOT_ADDR: begin
          if (aw_fire) begin
            state <= dma_ctrl_pkg::BOOT_DATA;        // data phase next cycle
          end
        end
        dma_ctrl_pkg::BOOT_DATA: begin
          if (w_fire) begin
            state     <= dma_ctrl_pkg::BOOT_IDLE;
            entry_cnt <= entry_cnt + 1'b1;
          end
        end
        dma_ctrl_pkg::BOOT_DONE: begin
          state <= dma_ctrl_pkg::BOOT_DONE;          // parked until reset
        end
        default: begin
          state <= dma_ctrl_pkg::BOOT_IDLE;          // illegal code, restart
        end
      endcase
    end
  end

  ////////////////////
  // bus drive
  ////////////////////

  always_comb begin
    wr_req.awvalid = (state == dma_ctrl_pkg::BOOT_ADDR);
    wr_req.awaddr  = entry_addr;
    wr_req.wvalid  = (state == dma_ctrl_pkg::BOOT_DATA);
    wr_req.wdata   = dma_ctrl_pkg::RUN_BIT_VALUE;    // every entry sets run
  end

  assign cfg_done = (state == dma_ctrl_pkg::BOOT_DONE);

endmodule

// File: rtl/manual_lite_access.sv
`timescale 1ns/1ps

module manual_lite_access (
  input  logic                       pcie_clk,
  input  logic                       pcie_aresetn,
  input  logic                       wr_strobe,
  input  logic                       rd_strobe,
  input  dma_ctrl_pkg::lite_addr_t   wr_addr,
  input  dma_ctrl_pkg::lite_data_t   wr_data,
  input  dma_ctrl_pkg::lite_addr_t   rd_addr,
  output dma_ctrl_pkg::lite_wr_req_t wr_req,
  input  dma_ctrl_pkg::lite_wr_rsp_t wr_rsp,
  output dma_ctrl_pkg::lite_rd_req_t rd_req,
  input  dma_ctrl_pkg::lite_rd_rsp_t rd_rsp,
  output dma_ctrl_pkg::lite_data_t   rd_data
);

  logic wr_r;
  logic wr_rr;
  logic rd_r;
  logic rd_rr;
  logic wr_rise;
  logic rd_rise;
  logic awvalid_q;
  logic wvalid_q;
  logic arvalid_q;
  logic aw_fire;
  logic w_fire;
  logic ar_fire;
  logic r_fire;

  ////////////////////
  // strobe edges
  ////////////////////

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      wr_r  <= 1'b0;
      wr_rr <= 1'b0;
      rd_r  <= 1'b0;
      rd_rr <= 1'b0;
    end else begin
      wr_r  <= wr_strobe;                  // first sample
      wr_rr <= wr_r;
      rd_r  <= rd_strobe;
      rd_rr <= rd_r;
    end
  end

  assign wr_rise = wr_r & ~wr_rr;          // one pulse per level rise
  assign rd_rise = rd_r & ~rd_rr;

  assign aw_fire = awvalid_q & wr_rsp.awready;
  assign w_fire  = wvalid_q & wr_rsp.wready;
  assign ar_fire = arvalid_q & rd_rsp.arready;
  assign r_fire  = rd_rsp.rvalid & rd_req.rready;

  ////////////////////
  // valid flags
  ////////////////////

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      arvalid_q <= 1'b0;
    end else begin
      if (wr_rise) begin
        awvalid_q <= 1'b1;
      end else if (aw_fire) begin
        awvalid_q <= 1'b0;
      end
      // data phase opens only after the address has gone
      if (aw_fire) begin
        wvalid_q <= 1'b1;
      end else if (w_fire) begin
        wvalid_q <= 1'b0;
      end
      if (rd_rise) begin
        arvalid_q <= 1'b1;
      end else if (ar_fire) begin
        arvalid_q <= 1'b0;
      end
    end
  end

  // read word capture, holds between reads
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      rd_data <= '0;
    end else if (r_fire) begin
      rd_data <= rd_rsp.rdata;
    end
  end

  assign wr_req = '{awvalid: awvalid_q, awaddr: wr_addr, wvalid: wvalid_q, wdata: wr_data};
  assign rd_req = '{arvalid: arvalid_q, araddr: rd_addr, rready: 1'b1};

endmodule

// File: rtl/lite_port_mux.sv
`timescale 1ns/1ps

module lite_port_mux (
  input  logic                       sel_manual,   // high once boot is done
  input  dma_ctrl_pkg::lite_wr_req_t boot_wr_req,
  input  dma_ctrl_pkg::lite_wr_req_t man_wr_req,
  output dma_ctrl_pkg::lite_wr_req_t wr_req,
  input  dma_ctrl_pkg::lite_wr_rsp_t wr_rsp,
  output dma_ctrl_pkg::lite_wr_rsp_t boot_wr_rsp,
  output dma_ctrl_pkg::lite_wr_rsp_t man_wr_rsp
);

  ////////////////////
  // request path
  ////////////////////

  always_comb begin
    if (sel_manual) begin
      wr_req = man_wr_req;                  // host strobes own the bus
    end else begin
      wr_req = boot_wr_req;                 // sequencer still running
    end
  end

  ////////////////////
  // response path
  ////////////////////

  // the unselected side sees no ready at all
  // so a manual write raised during boot just waits
  always_comb begin
    boot_wr_rsp = '0;
    man_wr_rsp  = '0;
    if (sel_manual) begin
      man_wr_rsp = wr_rsp;
    end else begin
      boot_wr_rsp = wr_rsp;
    end
  end

endmodule

// File: rtl/dma_ctrl_front.sv
`timescale 1ns/1ps

module dma_ctrl_front #(
  parameter int NUM_CHANNELS = 4
) (
  input  logic                       pcie_clk,
  input  logic                       pcie_aresetn,
  // host side register access
  input  logic                       wr_strobe,      // level, rise = one write
  input  logic                       rd_strobe,      // level, rise = one read
  input  dma_ctrl_pkg::lite_addr_t   wr_addr,
  input  dma_ctrl_pkg::lite_data_t   wr_data,
  input  dma_ctrl_pkg::lite_addr_t   rd_addr,
  output dma_ctrl_pkg::lite_data_t   rd_data,
  output logic                       cfg_done,
  // dma control port
  output dma_ctrl_pkg::lite_wr_req_t m_lite_wr,
  input  dma_ctrl_pkg::lite_wr_rsp_t m_lite_wr_rsp,
  output dma_ctrl_pkg::lite_rd_req_t m_lite_rd,
  input  dma_ctrl_pkg::lite_rd_rsp_t m_lite_rd_rsp
);

  dma_ctrl_pkg::lite_wr_req_t boot_wr_req;
  dma_ctrl_pkg::lite_wr_rsp_t boot_wr_rsp;
  dma_ctrl_pkg::lite_wr_req_t man_wr_req;
  dma_ctrl_pkg::lite_wr_rsp_t man_wr_rsp;

  ////////////////////
  // boot writes
  ////////////////////

  boot_config_seq #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) boot_config_seq_i (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .wr_req       (boot_wr_req),
    .wr_rsp       (boot_wr_rsp),
    .cfg_done     (cfg_done)
  );

  // reads bypass the mux
  manual_lite_access manual_lite_access_i (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .wr_strobe    (wr_strobe),
    .rd_strobe    (rd_strobe),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_addr      (rd_addr),
    .wr_req       (man_wr_req),
    .wr_rsp       (man_wr_rsp),
    .rd_req       (m_lite_rd),
    .rd_rsp       (m_lite_rd_rsp),
    .rd_data      (rd_data)
  );

  ////////////////////
  // write port share
  ////////////////////

  lite_port_mux lite_port_mux_i (
    .sel_manual   (cfg_done),             // hand over after last boot write
    .boot_wr_req  (boot_wr_req),
    .man_wr_req   (man_wr_req),
    .wr_req       (m_lite_wr),
    .wr_rsp       (m_lite_wr_rsp),
    .boot_wr_rsp  (boot_wr_rsp),
    .man_wr_rsp   (man_wr_rsp)
  );

endmodule

// File: testbench/lite_slave_model.sv
`timescale 1ns/1ps

module lite_slave_model (
  input  logic                       pcie_clk,
  input  logic                       pcie_aresetn,
  input  dma_ctrl_pkg::lite_wr_req_t wr_req,
  output dma_ctrl_pkg::lite_wr_rsp_t wr_rsp,
  input  dma_ctrl_pkg::lite_rd_req_t rd_req,
  output dma_ctrl_pkg::lite_rd_rsp_t rd_rsp
);

  logic [1:0]  aw_wait;                  // cycles left before awready
  logic [1:0]  w_wait;
  logic [1:0]  ar_wait;
  logic [1:0]  r_wait;                   // cycles left before rvalid
  logic        r_busy;                   // read accepted, answer owed
  logic [31:0] rdata_q;
  logic [31:0] aw_addr_q;                // address of the write in flight
  logic        aw_fire;
  logic        w_fire;
  logic        ar_fire;
  logic [31:0] log_addr[$];              // completed writes, oldest first
  logic [31:0] log_data[$];

  function automatic logic [1:0] rand_delay(input int unsigned max_val);
    int unsigned r;
    r = $urandom % (max_val + 1);
    return r[1:0];
  endfunction

  always_comb begin
    wr_rsp.awready = wr_req.awvalid & (aw_wait == 2'd0);
    wr_rsp.wready  = wr_req.wvalid & (w_wait == 2'd0);
    rd_rsp.arready = rd_req.arvalid & (ar_wait == 2'd0) & ~r_busy;
    rd_rsp.rvalid  = r_busy & (r_wait == 2'd0);
    rd_rsp.rdata   = rdata_q;
  end

  assign aw_fire = wr_req.awvalid & wr_rsp.awready;
  assign w_fire  = wr_req.wvalid & wr_rsp.wready;
  assign ar_fire = rd_req.arvalid & rd_rsp.arready;

  always @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      aw_wait   <= rand_delay(3);
      w_wait    <= rand_delay(3);
      ar_wait   <= rand_delay(3);
      r_wait    <= 2'd0;
      r_busy    <= 1'b0;
      rdata_q   <= '0;
      aw_addr_q <= '0;
      log_addr.delete();                 // log restarts with every reset
      log_data.delete();
    end else begin
      if (aw_fire) begin
        aw_wait   <= rand_delay(3);      // new delay for the next write
        aw_addr_q <= wr_req.awaddr;
      end else if (wr_req.awvalid && aw_wait != 2'd0) begin
        aw_wait <= aw_wait - 2'd1;
      end
      if (w_fire) begin
        w_wait <= rand_delay(3);
        log_addr.push_back(aw_addr_q);
        log_data.push_back(wr_req.wdata);
      end else if (wr_req.wvalid && w_wait != 2'd0) begin
        w_wait <= w_wait - 2'd1;
      end
      if (ar_fire) begin
        ar_wait <= rand_delay(3);
        r_busy  <= 1'b1;
        r_wait  <= rand_delay(2);        // answer 1 to 3 cycles later
        rdata_q <= rd_req.araddr ^ 32'hA5A5_0000;
      end else begin
        if (rd_req.arvalid && ar_wait != 2'd0) begin
          ar_wait <= ar_wait - 2'd1;
        end
        if (r_busy && r_wait != 2'd0) begin
          r_wait <= r_wait - 2'd1;
        end else if (r_busy && rd_req.rready) begin
          r_busy <= 1'b0;                // rvalid transfer done
        end
      end
    end
  end

  function automatic int log_count();
    return log_addr.size();
  endfunction

  function automatic logic [31:0] log_addr_at(input int idx);
    return log_addr[idx];
  endfunction

  function automatic logic [31:0] log_data_at(input int idx);
    return log_data[idx];
  endfunction

endmodule

// File: testbench/dma_ctrl_front_assert.sv
`timescale 1ns/1ps

module dma_ctrl_front_assert (
  input logic                       pcie_clk,
  input logic                       pcie_aresetn,
  input logic                       cfg_done,
  input dma_ctrl_pkg::lite_wr_req_t m_lite_wr,
  input dma_ctrl_pkg::lite_wr_rsp_t m_lite_wr_rsp,
  input dma_ctrl_pkg::lite_rd_req_t m_lite_rd,
  input dma_ctrl_pkg::lite_rd_rsp_t m_lite_rd_rsp
);

  logic aw_taken;                        // address sent, data phase owed

  always @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      aw_taken <= 1'b0;
    end else if (m_lite_wr.awvalid && m_lite_wr_rsp.awready) begin
      aw_taken <= 1'b1;
    end else if (m_lite_wr.wvalid && m_lite_wr_rsp.wready) begin
      aw_taken <= 1'b0;
    end
  end

  ////////////////////
  // bus rules
  ////////////////////

  aw_hold: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    (m_lite_wr.awvalid && !m_lite_wr_rsp.awready) |=>
      (m_lite_wr.awvalid && $stable(m_lite_wr.awaddr)))
    else $error("write address phase changed before awready");

  w_hold: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    (m_lite_wr.wvalid && !m_lite_wr_rsp.wready) |=>
      (m_lite_wr.wvalid && $stable(m_lite_wr.wdata)))
    else $error("write data phase changed before wready");

  ar_hold: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    (m_lite_rd.arvalid && !m_lite_rd_rsp.arready) |=>
      (m_lite_rd.arvalid && $stable(m_lite_rd.araddr)))
    else $error("read address phase changed before arready");

  w_after_aw: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    m_lite_wr.wvalid |-> aw_taken)
    else $error("wvalid raised before its address transfer");

  // boot completion is sticky
  done_sticky: assert property (@(posedge pcie_clk) disable iff (!pcie_aresetn)
    cfg_done |=> cfg_done)
    else $error("cfg_done fell without reset");

endmodule

bind dma_ctrl_front dma_ctrl_front_assert dma_ctrl_front_assert_i (
  .pcie_clk      (pcie_clk),
  .pcie_aresetn  (pcie_aresetn),
  .cfg_done      (cfg_done),
  .m_lite_wr     (m_lite_wr),
  .m_lite_wr_rsp (m_lite_wr_rsp),
  .m_lite_rd     (m_lite_rd),
  .m_lite_rd_rsp (m_lite_rd_rsp)
);

// File: testbench/tb_dma_ctrl_front.sv
`timescale 1ns/1ps

module tb_dma_ctrl_front;

  localparam int NUM_CH     = 4;
  localparam int RST_CYCLES = 16;
  localparam int BOOT_TMO   = 400;       // cycles for the whole boot table
  localparam int PHASE_TMO  = 60;        // cycles for one manual access

  logic                       pcie_clk;
  logic                       pcie_aresetn;
  logic                       wr_strobe;
  logic                       rd_strobe;
  dma_ctrl_pkg::lite_addr_t   wr_addr;
  dma_ctrl_pkg::lite_data_t   wr_data;
  dma_ctrl_pkg::lite_addr_t   rd_addr;
  dma_ctrl_pkg::lite_data_t   rd_data;
  logic                       cfg_done;
  dma_ctrl_pkg::lite_wr_req_t m_lite_wr;
  dma_ctrl_pkg::lite_wr_rsp_t m_lite_wr_rsp;
  dma_ctrl_pkg::lite_rd_req_t m_lite_rd;
  dma_ctrl_pkg::lite_rd_rsp_t m_lite_rd_rsp;

  int error_cnt;
  int test_cnt;
  int test_fail_cnt;
  int seed_ret;

  dma_ctrl_front #(.NUM_CHANNELS(NUM_CH)) dma_ctrl_front_i (.*);

  lite_slave_model slave_i (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .wr_req       (m_lite_wr),
    .wr_rsp       (m_lite_wr_rsp),
    .rd_req       (m_lite_rd),
    .rd_rsp       (m_lite_rd_rsp)
  );

  initial pcie_clk = 1'b0;
  always #4 pcie_clk = ~pcie_clk;        // 8 ns period

  ////////////////////
  // helpers
  ////////////////////

  // inputs move 1 ns past the rising edge
  task automatic step_clk(input int n);
    repeat (n) @(posedge pcie_clk);
    #1;
  endtask

  task automatic report_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("[FAIL] %0d ns: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
    error_cnt++;
  endtask

  // boot table for four channels, starts at channel 1 and wraps to 0
  function automatic logic [31:0] expected_boot_addr(input int idx);
    logic [31:0] addr;
    case (idx)
      0:       addr = 32'h0000_0104;
      1:       addr = 32'h0000_1104;
      2:       addr = 32'h0000_0204;
      3:       addr = 32'h0000_1204;
      4:       addr = 32'h0000_0304;
      5:       addr = 32'h0000_1304;
      6:       addr = 32'h0000_0004;
      7:       addr = 32'h0000_1004;
      default: addr = 32'hFFFF_FFFF;  // past the table
    endcase
    return addr;
  endfunction

  task automatic check_idle_outputs(input string when);
    if (m_lite_wr.awvalid !== 1'b0 || m_lite_wr.wvalid !== 1'b0 ||
        m_lite_rd.arvalid !== 1'b0) begin
      report_value({when, " aw/w/ar valids"},
                   {29'd0, m_lite_wr.awvalid, m_lite_wr.wvalid, m_lite_rd.arvalid}, 32'd0);
    end
    if (cfg_done !== 1'b0) begin
      report_value({when, " cfg_done"}, {31'd0, cfg_done}, 32'd0);
    end
    if (rd_data !== 32'd0) begin
      report_value({when, " rd_data"}, rd_data, 32'd0);
    end
  endtask

  task automatic wait_log_count(input int target, input int max_cycles);
    int n;
    n = 0;
    while (slave_i.log_count() < target && n < max_cycles) begin
      step_clk(1);
      n++;
    end
    if (slave_i.log_count() < target) begin
      $display("timeout: write log holds %0d entries, %0d expected within %0d cycles",
               slave_i.log_count(), target, max_cycles);
      error_cnt++;
    end
  endtask

  task automatic wait_cfg_done(input int max_cycles);
    int n;
    n = 0;
    while (cfg_done !== 1'b1 && n < max_cycles) begin
      step_clk(1);
      n++;
    end
    if (cfg_done !== 1'b1) begin
      $display("timeout: cfg_done still low after %0d cycles", max_cycles);
      error_cnt++;
    end
  endtask

  task automatic wait_rvalid(input int max_cycles);
    int n;
    n = 0;
    while (m_lite_rd_rsp.rvalid !== 1'b1 && n < max_cycles) begin
      step_clk(1);
      n++;
    end
    if (m_lite_rd_rsp.rvalid !== 1'b1) begin
      $display("timeout: no read response within %0d cycles", max_cycles);
      error_cnt++;
    end
  endtask

  // first entries of the log against the boot table
  task automatic check_boot_entries(input int cnt);
    int i;
    for (i = 0; i < cnt && i < 2 * NUM_CH; i++) begin
      if (slave_i.log_addr_at(i) !== expected_boot_addr(i)) begin
        report_value($sformatf("boot entry %0d addr", i), slave_i.log_addr_at(i),
                     expected_boot_addr(i));
      end
      if (slave_i.log_data_at(i) !== 32'h0000_0001) begin
        report_value($sformatf("boot entry %0d data", i), slave_i.log_data_at(i), 32'h1);
      end
    end
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    test_cnt++;
    if (error_cnt == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      test_fail_cnt++;
      $display("test %s: %0d error(s)", name, error_cnt - errs_at_start);
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_reset();
    int errs;
    int i;
    errs = error_cnt;
    pcie_aresetn = 1'b0;
    step_clk(1);                         // first edge loads reset values
    for (i = 1; i < RST_CYCLES; i++) begin
      check_idle_outputs("in reset");
      step_clk(1);
    end
    pcie_aresetn = 1'b1;
    check_idle_outputs("after reset");
    finish_test("reset", errs);
  endtask

  task automatic test_boot_sequence();
    int errs;
    int cnt;
    errs = error_cnt;
    wait_log_count(2 * NUM_CH, BOOT_TMO);
    wait_cfg_done(4);                    // one idle cycle, then done
    cnt = slave_i.log_count();
    if (cnt != 2 * NUM_CH) begin
      report_value("boot write count", cnt, 2 * NUM_CH);
    end
    check_boot_entries(cnt);
    step_clk(20);
    if (slave_i.log_count() != 2 * NUM_CH) begin
      report_value("write count after boot", slave_i.log_count(), 2 * NUM_CH);
    end
    finish_test("boot sequence", errs);
  endtask

  task automatic test_manual_write(input logic [31:0] addr, input logic [31:0] data);
    int errs;
    int base;
    errs = error_cnt;
    base = slave_i.log_count();
    if (cfg_done !== 1'b1) begin
      $display("manual write started while boot was still running");
      error_cnt++;
    end
    wr_addr   = addr;
    wr_data   = data;
    wr_strobe = 1'b1;
    wait_log_count(base + 1, PHASE_TMO);
    if (slave_i.log_count() > base) begin
      if (slave_i.log_addr_at(base) !== addr) begin
        report_value("manual write addr", slave_i.log_addr_at(base), addr);
      end
      if (slave_i.log_data_at(base) !== data) begin
        report_value("manual write data", slave_i.log_data_at(base), data);
      end
    end
    step_clk(20);                        // held strobe, no second write
    if (slave_i.log_count() != base + 1) begin
      report_value("write count with strobe held", slave_i.log_count(), base + 1);
    end
    wr_strobe = 1'b0;
    step_clk(3);
    finish_test("manual write", errs);
  endtask

  task automatic test_manual_read();
    int          errs;
    int          i;
    logic [31:0] addr;
    logic [31:0] expected;
    errs = error_cnt;
    for (i = 0; i < 3; i++) begin
      addr      = $urandom & 32'h0000_FFFC;   // word aligned
      expected  = addr ^ 32'hA5A5_0000;
      rd_addr   = addr;
      rd_strobe = 1'b1;
      wait_rvalid(PHASE_TMO);
      step_clk(1);                       // capture lands after the transfer
      if (rd_data !== expected) begin
        report_value($sformatf("rd_data for 0x%08h", addr), rd_data, expected);
      end
      rd_strobe = 1'b0;
      step_clk(3);
    end
    finish_test("manual read", errs);
  endtask

  task automatic test_write_during_boot();
    int errs;
    int cnt;
    errs = error_cnt;
    pcie_aresetn = 1'b0;
    step_clk(RST_CYCLES);
    pcie_aresetn = 1'b1;
    wr_addr   = 32'h0000_2010;
    wr_data   = 32'h5A5A_00C3;
    wr_strobe = 1'b1;                    // raised while boot is running
    wait_log_count(2 * NUM_CH + 1, BOOT_TMO);
    cnt = slave_i.log_count();
    if (cnt != 2 * NUM_CH + 1) begin
      report_value("write count boot plus manual", cnt, 2 * NUM_CH + 1);
    end
    check_boot_entries(cnt);
    if (cnt > 2 * NUM_CH) begin
      if (slave_i.log_addr_at(2 * NUM_CH) !== 32'h0000_2010) begin
        report_value("late manual addr", slave_i.log_addr_at(2 * NUM_CH), 32'h0000_2010);
      end
      if (slave_i.log_data_at(2 * NUM_CH) !== 32'h5A5A_00C3) begin
        report_value("late manual data", slave_i.log_data_at(2 * NUM_CH), 32'h5A5A_00C3);
      end
    end
    wr_strobe = 1'b0;
    step_clk(3);
    finish_test("write during boot", errs);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    seed_ret      = $urandom(84614);     // one seed for the run
    error_cnt     = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    pcie_aresetn  = 1'b0;
    wr_strobe     = 1'b0;
    rd_strobe     = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    rd_addr       = '0;
    test_reset();
    test_boot_sequence();
    test_manual_write(32'h0000_1208, 32'hDEAD_0001);
    test_manual_read();
    test_write_during_boot();
    $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, test_fail_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
rtl/dma_ctrl_pkg.sv
rtl/boot_config_seq.sv
rtl/manual_lite_access.sv
rtl/lite_port_mux.sv
rtl/dma_ctrl_front.sv
testbench/lite_slave_model.sv
testbench/dma_ctrl_front_assert.sv
testbench/tb_dma_ctrl_front.sv
